// ==== src/cpu_types_pkg.sv ====
// datapath widths, word, register index and instruction types
package cpu_types_pkg;

    // datapath width
    localparam int WORD_W = 32;

    // register index width
    localparam int REG_W = 5;

    // jump target field in the instruction
    localparam int IMM26_W = 26;

    // data or address word
    typedef logic [WORD_W-1:0] word_t;

    // register index
    typedef logic [REG_W-1:0] regbits_t;

    // raw instruction word, jump field sits in the low IMM26_W bits
    typedef logic [WORD_W-1:0] instr_t;

endpackage

// ==== src/pipe_types_pkg.sv ====
// writeback source select encoding and register file depth
package pipe_types_pkg;

    // width of the writeback source select
    localparam int WBSEL_W = 2;

    // number of architectural registers
    localparam int NUM_REGS = 32;

    // source of the register write data
    // WB_LOAD is only valid after the memory stage
    typedef enum logic [WBSEL_W-1:0] {
        // alu result
        WB_ALU  = 2'd0,
        // next pc, for link instructions
        WB_NPC  = 2'd1,
        // data read from memory
        WB_LOAD = 2'd2,
        // extended immediate, e.g. lui
        WB_IMM  = 2'd3
    } wbsel_t;

endpackage

// ==== src/data_memory.sv ====
// data memory: word array with combinational read, clocked write and hit strobe
`timescale 1ns/1ps

module data_memory #(
    parameter int MEM_WORDS = 256
) (
    input  logic                 CLK,
    input  logic                 dmem_ren,
    input  logic                 dmem_wen,
    input  cpu_types_pkg::word_t dmem_addr,
    input  cpu_types_pkg::word_t dmem_store,
    output cpu_types_pkg::word_t dmem_load,
    output logic                 dhit
);

    import cpu_types_pkg::*;

    localparam int ADDR_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

    word_t             mem [MEM_WORDS];
    logic [ADDR_W-1:0] word_idx;

    // byte address to word index, wrapped to the array depth
    assign word_idx = ADDR_W'(dmem_addr[WORD_W-1:2] % MEM_WORDS);

    // no latency, every request completes in the same cycle
    assign dhit = dmem_ren | dmem_wen;

    // zero when not reading so idle cycles latch a known value
    assign dmem_load = dmem_ren ? mem[word_idx] : '0;

    always_ff @(posedge CLK) begin
        if (dmem_wen) begin
            mem[word_idx] <= dmem_store;
        end
    end

endmodule

// ==== src/memory_stage.sv ====
// memory stage: data request, branch and jump targets, forwarding data, mem/wb latch
`timescale 1ns/1ps

module memory_stage (
    input  logic                     CLK,
    input  logic                     nRST,
    // pipeline strobes
    input  logic                     ihit,
    input  logic                     dhit,
    input  logic                     flush,
    input  logic                     freeze,
    // execute/memory latch fields
    input  cpu_types_pkg::regbits_t  ex_rw,
    input  logic                     ex_reg_wen,
    input  pipe_types_pkg::wbsel_t   ex_wbsel,
    input  logic                     ex_halt,
    input  cpu_types_pkg::word_t     ex_npc,
    input  cpu_types_pkg::word_t     ex_port_a,
    input  cpu_types_pkg::word_t     ex_port_b,
    input  cpu_types_pkg::word_t     ex_port_o,
    input  cpu_types_pkg::word_t     ex_imm_ext,
    input  cpu_types_pkg::instr_t    ex_instr,
    input  logic                     ex_dren,
    input  logic                     ex_dwen,
    // data memory
    input  cpu_types_pkg::word_t     dmem_load,
    output logic                     dmem_ren,
    output logic                     dmem_wen,
    output cpu_types_pkg::word_t     dmem_addr,
    output cpu_types_pkg::word_t     dmem_store,
    // toward fetch and the forwarding unit
    output cpu_types_pkg::word_t     branch_addr,
    output cpu_types_pkg::word_t     jump_addr,
    output cpu_types_pkg::word_t     port_a,
    output cpu_types_pkg::word_t     fwd_data,
    // memory/writeback latch
    output cpu_types_pkg::regbits_t  mem_rw,
    output logic                     mem_reg_wen,
    output pipe_types_pkg::wbsel_t   mem_wbsel,
    output logic                     mem_halt,
    output cpu_types_pkg::word_t     mem_npc,
    output cpu_types_pkg::word_t     mem_port_o,
    output cpu_types_pkg::word_t     mem_load,
    output cpu_types_pkg::word_t     mem_imm_ext
);

    import cpu_types_pkg::*;
    import pipe_types_pkg::*;

    // rw, reg_wen, wbsel, halt, then four words
    localparam int LATCH_W = REG_W + 1 + WBSEL_W + 1 + 4 * WORD_W;

    logic [LATCH_W-1:0] latch_d;
    logic [LATCH_W-1:0] latch_q;

    // data memory request, address from the alu and store data from rt
    assign dmem_ren   = ex_dren;
    assign dmem_wen   = ex_dwen;
    assign dmem_addr  = ex_port_o;
    assign dmem_store = ex_port_b;

    // pc relative branch, word offset
    assign branch_addr = ex_npc + {ex_imm_ext[WORD_W-3:0], 2'b00};

    // pseudo-direct jump within the current 256 MB region
    assign jump_addr = {ex_npc[WORD_W-1:WORD_W-4], ex_instr[IMM26_W-1:0], 2'b00};

    assign port_a = ex_port_a;

    // value this instruction will write back, as far as it is known here
    always_comb begin
        unique case (ex_wbsel)
            WB_ALU:  fwd_data = ex_port_o;
            WB_NPC:  fwd_data = ex_npc;
            // load data not back yet
            WB_LOAD: fwd_data = '0;
            WB_IMM:  fwd_data = ex_imm_ext;
            default: fwd_data = '0;
        endcase
    end

    assign latch_d = {ex_rw, ex_reg_wen, ex_wbsel, ex_halt,
                      ex_npc, ex_port_o, dmem_load, ex_imm_ext};

    // flush beats freeze, freeze beats a hit
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            latch_q <= '0;
        end else if (flush) begin
            latch_q <= '0;
        end else if (freeze) begin
            latch_q <= latch_q;
        end else if (ihit | dhit) begin
            latch_q <= latch_d;
        end
    end

    assign {mem_rw, mem_reg_wen, mem_wbsel, mem_halt,
            mem_npc, mem_port_o, mem_load, mem_imm_ext} = latch_q;

endmodule

// ==== src/writeback_stage.sv ====
// writeback stage: register write data select and write enable
`timescale 1ns/1ps

module writeback_stage (
    input  cpu_types_pkg::regbits_t mem_rw,
    input  logic                    mem_reg_wen,
    input  pipe_types_pkg::wbsel_t  mem_wbsel,
    input  cpu_types_pkg::word_t    mem_npc,
    input  cpu_types_pkg::word_t    mem_port_o,
    input  cpu_types_pkg::word_t    mem_load,
    input  cpu_types_pkg::word_t    mem_imm_ext,
    output logic                    reg_wen,
    output cpu_types_pkg::regbits_t reg_wsel,
    output cpu_types_pkg::word_t    reg_wdat
);

    import cpu_types_pkg::*;
    import pipe_types_pkg::*;

    regbits_t dest;

    assign dest     = mem_rw;
    assign reg_wsel = dest;
    assign reg_wen  = mem_reg_wen;

    // load data is available at this point
    always_comb begin
        unique case (mem_wbsel)
            WB_ALU:  reg_wdat = mem_port_o;
            WB_NPC:  reg_wdat = mem_npc;
            WB_LOAD: reg_wdat = mem_load;
            WB_IMM:  reg_wdat = mem_imm_ext;
            default: reg_wdat = mem_port_o;
        endcase
    end

endmodule

// ==== src/register_file.sv ====
// register file: NUM_REGS words, register zero hardwired, two read ports
`timescale 1ns/1ps

module register_file (
    input  logic                    CLK,
    input  logic                    nRST,
    input  logic                    reg_wen,
    input  cpu_types_pkg::regbits_t reg_wsel,
    input  cpu_types_pkg::word_t    reg_wdat,
    input  cpu_types_pkg::regbits_t rsel1,
    input  cpu_types_pkg::regbits_t rsel2,
    output cpu_types_pkg::word_t    rdat1,
    output cpu_types_pkg::word_t    rdat2
);

    import cpu_types_pkg::*;
    import pipe_types_pkg::*;

    word_t regs [NUM_REGS];
    logic  wr_ok;

    // writes to r0 are dropped
    assign wr_ok = reg_wen && (reg_wsel != '0);

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_ok) begin
            regs[reg_wsel] <= reg_wdat;
        end
    end

    // no write-through, a write shows up after the edge
    assign rdat1 = (rsel1 == '0) ? '0 : regs[rsel1];
    assign rdat2 = (rsel2 == '0) ? '0 : regs[rsel2];

endmodule

// ==== src/mem_wb_top.sv ====
// top level: memory stage, data memory, writeback stage and register file
`timescale 1ns/1ps

module mem_wb_top #(
    parameter int MEM_WORDS = 256
) (
    input  logic                    CLK,
    input  logic                    nRST,
    // execute/memory latch fields
    input  cpu_types_pkg::regbits_t ex_rw,
    input  logic                    ex_reg_wen,
    input  pipe_types_pkg::wbsel_t  ex_wbsel,
    input  logic                    ex_halt,
    input  cpu_types_pkg::word_t    ex_npc,
    input  cpu_types_pkg::word_t    ex_port_a,
    input  cpu_types_pkg::word_t    ex_port_b,
    input  cpu_types_pkg::word_t    ex_port_o,
    input  cpu_types_pkg::word_t    ex_imm_ext,
    input  cpu_types_pkg::instr_t   ex_instr,
    input  logic                    ex_dren,
    input  logic                    ex_dwen,
    // strobes
    input  logic                    ihit,
    input  logic                    flush,
    input  logic                    freeze,
    // register read selects
    input  cpu_types_pkg::regbits_t rsel1,
    input  cpu_types_pkg::regbits_t rsel2,
    // outputs
    output cpu_types_pkg::word_t    branch_addr,
    output cpu_types_pkg::word_t    jump_addr,
    output cpu_types_pkg::word_t    port_a,
    output cpu_types_pkg::word_t    fwd_data,
    output cpu_types_pkg::word_t    rdat1,
    output cpu_types_pkg::word_t    rdat2,
    output logic                    halt
);

    import cpu_types_pkg::*;
    import pipe_types_pkg::*;

    // data memory side
    logic     dmem_ren;
    logic     dmem_wen;
    word_t    dmem_addr;
    word_t    dmem_store;
    word_t    dmem_load;
    logic     dhit;

    // memory/writeback latch
    regbits_t mem_rw;
    logic     mem_reg_wen;
    wbsel_t   mem_wbsel;
    word_t    mem_npc;
    word_t    mem_port_o;
    word_t    mem_load;
    word_t    mem_imm_ext;

    // register write port
    logic     reg_wen;
    regbits_t reg_wsel;
    word_t    reg_wdat;

    data_memory #(
        .MEM_WORDS (MEM_WORDS)
    ) data_memory_inst (
        .CLK        (CLK),
        .dmem_ren   (dmem_ren),
        .dmem_wen   (dmem_wen),
        .dmem_addr  (dmem_addr),
        .dmem_store (dmem_store),
        .dmem_load  (dmem_load),
        .dhit       (dhit)
    );

    memory_stage memory_stage_inst (
        .CLK         (CLK),
        .nRST        (nRST),
        .ihit        (ihit),
        .dhit        (dhit),
        .flush       (flush),
        .freeze      (freeze),
        .ex_rw       (ex_rw),
        .ex_reg_wen  (ex_reg_wen),
        .ex_wbsel    (ex_wbsel),
        .ex_halt     (ex_halt),
        .ex_npc      (ex_npc),
        .ex_port_a   (ex_port_a),
        .ex_port_b   (ex_port_b),
        .ex_port_o   (ex_port_o),
        .ex_imm_ext  (ex_imm_ext),
        .ex_instr    (ex_instr),
        .ex_dren     (ex_dren),
        .ex_dwen     (ex_dwen),
        .dmem_load   (dmem_load),
        .dmem_ren    (dmem_ren),
        .dmem_wen    (dmem_wen),
        .dmem_addr   (dmem_addr),
        .dmem_store  (dmem_store),
        .branch_addr (branch_addr),
        .jump_addr   (jump_addr),
        .port_a      (port_a),
        .fwd_data    (fwd_data),
        .mem_rw      (mem_rw),
        .mem_reg_wen (mem_reg_wen),
        .mem_wbsel   (mem_wbsel),
        // latched halt goes straight out
        .mem_halt    (halt),
        .mem_npc     (mem_npc),
        .mem_port_o  (mem_port_o),
        .mem_load    (mem_load),
        .mem_imm_ext (mem_imm_ext)
    );

    writeback_stage writeback_stage_inst (
        .mem_rw      (mem_rw),
        .mem_reg_wen (mem_reg_wen),
        .mem_wbsel   (mem_wbsel),
        .mem_npc     (mem_npc),
        .mem_port_o  (mem_port_o),
        .mem_load    (mem_load),
        .mem_imm_ext (mem_imm_ext),
        .reg_wen     (reg_wen),
        .reg_wsel    (reg_wsel),
        .reg_wdat    (reg_wdat)
    );

    register_file register_file_inst (
        .CLK      (CLK),
        .nRST     (nRST),
        .reg_wen  (reg_wen),
        .reg_wsel (reg_wsel),
        .reg_wdat (reg_wdat),
        .rsel1    (rsel1),
        .rsel2    (rsel2),
        .rdat1    (rdat1),
        .rdat2    (rdat2)
    );

endmodule

// ==== bench/mem_wb_asserts.sv ====
// concurrent assertions on the mem/wb latch flush, freeze and data request capture
`timescale 1ns/1ps

module mem_wb_asserts (
    input logic CLK,
    input logic nRST,
    input logic flush,
    input logic freeze,
    input logic dmem_ren,
    input logic dmem_wen,
    input logic [cpu_types_pkg::REG_W + pipe_types_pkg::WBSEL_W + 2
                 + 4 * cpu_types_pkg::WORD_W - 1:0] latch_d,
    input logic [cpu_types_pkg::REG_W + pipe_types_pkg::WBSEL_W + 2
                 + 4 * cpu_types_pkg::WORD_W - 1:0] latch_q
);

    // flush clears the whole latch
    assert property (@(posedge CLK) disable iff (!nRST) flush |=> (latch_q == '0))
        else $error("latch not cleared after flush");

    // freeze holds unless flush wins
    assert property (@(posedge CLK) disable iff (!nRST)
                     (freeze && !flush) |=> (latch_q == $past(latch_q)))
        else $error("latch changed during freeze");

    // a data request alone is enough to capture
    assert property (@(posedge CLK) disable iff (!nRST)
                     (!flush && !freeze && (dmem_ren || dmem_wen))
                     |=> (latch_q == $past(latch_d)))
        else $error("latch did not capture on a data request");

endmodule

bind memory_stage mem_wb_asserts mem_wb_asserts_inst (
    .CLK      (CLK),
    .nRST     (nRST),
    .flush    (flush),
    .freeze   (freeze),
    .dmem_ren (dmem_ren),
    .dmem_wen (dmem_wen),
    .latch_d  (latch_d),
    .latch_q  (latch_q)
);

// ==== bench/mem_wb_tb.sv ====
// testbench for mem_wb_top: clock, reset, random stimulus, reference model and checks
`timescale 1ns/1ps

module mem_wb_tb;

    import cpu_types_pkg::*;
    import pipe_types_pkg::*;

    localparam int MEM_WORDS  = 256;
    localparam int NUM_CYCLES = 600;
    localparam int HALT_LIMIT = 10;

    logic     CLK = 1'b0;
    logic     nRST;
    regbits_t ex_rw;
    logic     ex_reg_wen;
    wbsel_t   ex_wbsel;
    logic     ex_halt;
    word_t    ex_npc;
    word_t    ex_port_a;
    word_t    ex_port_b;
    word_t    ex_port_o;
    word_t    ex_imm_ext;
    instr_t   ex_instr;
    logic     ex_dren;
    logic     ex_dwen;
    logic     ihit;
    logic     flush;
    logic     freeze;
    regbits_t rsel1;
    regbits_t rsel2;
    word_t    branch_addr;
    word_t    jump_addr;
    word_t    port_a;
    word_t    fwd_data;
    word_t    rdat1;
    word_t    rdat2;
    logic     halt;

    int errors;
    int timeouts;

    // reference model: memory, latch copy and registers
    word_t    model_mem [MEM_WORDS];
    word_t    model_regs [NUM_REGS];
    regbits_t m_rw;
    logic     m_reg_wen;
    wbsel_t   m_wbsel;
    logic     m_halt;
    word_t    m_npc;
    word_t    m_port_o;
    word_t    m_load;
    word_t    m_imm_ext;
    // byte addresses already written, the only ones loads may use
    word_t    stored_addrs [$];

    mem_wb_top #(
        .MEM_WORDS (MEM_WORDS)
    ) mem_wb_top_inst (
        .CLK         (CLK),
        .nRST        (nRST),
        .ex_rw       (ex_rw),
        .ex_reg_wen  (ex_reg_wen),
        .ex_wbsel    (ex_wbsel),
        .ex_halt     (ex_halt),
        .ex_npc      (ex_npc),
        .ex_port_a   (ex_port_a),
        .ex_port_b   (ex_port_b),
        .ex_port_o   (ex_port_o),
        .ex_imm_ext  (ex_imm_ext),
        .ex_instr    (ex_instr),
        .ex_dren     (ex_dren),
        .ex_dwen     (ex_dwen),
        .ihit        (ihit),
        .flush       (flush),
        .freeze      (freeze),
        .rsel1       (rsel1),
        .rsel2       (rsel2),
        .branch_addr (branch_addr),
        .jump_addr   (jump_addr),
        .port_a      (port_a),
        .fwd_data    (fwd_data),
        .rdat1       (rdat1),
        .rdat2       (rdat2),
        .halt        (halt)
    );

    always #5 CLK = ~CLK;

    // byte address to word slot, wrapped to the memory depth
    function automatic int unsigned mem_index(word_t addr);
        return (addr >> 2) % MEM_WORDS;
    endfunction

    function automatic word_t writeback_value(wbsel_t sel, word_t npc, word_t alu,
                                              word_t load, word_t imm);
        case (sel)
            WB_ALU:  return alu;
            WB_NPC:  return npc;
            WB_LOAD: return load;
            default: return imm;
        endcase
    endfunction

    task automatic report_mismatch(string what, word_t got, word_t exp);
        $display("Mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        errors++;
    endtask

    task automatic clear_model_latch();
        m_rw      = '0;
        m_reg_wen = 1'b0;
        m_wbsel   = WB_ALU;
        m_halt    = 1'b0;
        m_npc     = '0;
        m_port_o  = '0;
        m_load    = '0;
        m_imm_ext = '0;
    endtask

    // rising edge: apply the inputs of the cycle that just ended to the model
    task automatic model_edge();
        word_t load_val;
        @(posedge CLK);
        if (m_reg_wen && m_rw != '0) begin
            model_regs[m_rw] = writeback_value(m_wbsel, m_npc, m_port_o, m_load, m_imm_ext);
        end
        // load sees memory from before a store of the same edge
        load_val = ex_dren ? model_mem[mem_index(ex_port_o)] : '0;
        if (ex_dwen) begin
            model_mem[mem_index(ex_port_o)] = ex_port_b;
        end
        if (flush) begin
            clear_model_latch();
        end else if (!freeze && (ihit || ex_dren || ex_dwen)) begin
            m_rw      = ex_rw;
            m_reg_wen = ex_reg_wen;
            m_wbsel   = ex_wbsel;
            m_halt    = ex_halt;
            m_npc     = ex_npc;
            m_port_o  = ex_port_o;
            m_load    = load_val;
            m_imm_ext = ex_imm_ext;
        end
    endtask

    task automatic drive_random();
        int unsigned kind;
        word_t       addr;
        logic        dren;
        logic        dwen;
        wbsel_t      sel;
        kind = $urandom % 8;
        addr = $urandom;
        dren = 1'b0;
        dwen = 1'b0;
        sel  = wbsel_t'($urandom % 4);
        if (kind < 2) begin
            dwen = 1'b1;
            stored_addrs.push_back(addr);
            if (stored_addrs.size() > 16) begin
                void'(stored_addrs.pop_front());
            end
        end else if (kind < 4 && stored_addrs.size() > 0) begin
            dren = 1'b1;
            sel  = WB_LOAD;
            addr = stored_addrs[$urandom % stored_addrs.size()];
        end
        ex_rw      <= regbits_t'($urandom);
        ex_reg_wen <= ($urandom % 4) != 0;
        ex_wbsel   <= sel;
        ex_halt    <= ($urandom % 16) == 0;
        ex_npc     <= $urandom;
        ex_port_a  <= $urandom;
        ex_port_b  <= $urandom;
        ex_port_o  <= addr;
        ex_imm_ext <= $urandom;
        ex_instr   <= $urandom;
        ex_dren    <= dren;
        ex_dwen    <= dwen;
        ihit       <= ($urandom % 10) < 7;
        flush      <= ($urandom % 25) == 0;
        freeze     <= ($urandom % 12) == 0;
        rsel1      <= regbits_t'($urandom);
        rsel2      <= regbits_t'($urandom);
    endtask

    // no hit and no data request, the latch holds
    task automatic drive_idle();
        ex_dren <= 1'b0;
        ex_dwen <= 1'b0;
        ihit    <= 1'b0;
        flush   <= 1'b0;
        freeze  <= 1'b0;
        rsel1   <= regbits_t'($urandom);
        rsel2   <= regbits_t'($urandom);
    endtask

    task automatic check_outputs();
        word_t exp_fwd;
        word_t exp_r1;
        word_t exp_r2;
        @(negedge CLK);
        case (ex_wbsel)
            WB_ALU:  exp_fwd = ex_port_o;
            WB_NPC:  exp_fwd = ex_npc;
            WB_LOAD: exp_fwd = '0;
            default: exp_fwd = ex_imm_ext;
        endcase
        exp_r1 = (rsel1 == '0) ? '0 : model_regs[rsel1];
        exp_r2 = (rsel2 == '0) ? '0 : model_regs[rsel2];
        if (branch_addr !== word_t'(ex_npc + (ex_imm_ext << 2))) begin
            report_mismatch("branch_addr", branch_addr, ex_npc + (ex_imm_ext << 2));
        end
        if (jump_addr !== {ex_npc[31:28], ex_instr[25:0], 2'b00}) begin
            report_mismatch("jump_addr", jump_addr, {ex_npc[31:28], ex_instr[25:0], 2'b00});
        end
        if (port_a !== ex_port_a) begin
            report_mismatch("port_a", port_a, ex_port_a);
        end
        if (fwd_data !== exp_fwd) begin
            report_mismatch("fwd_data", fwd_data, exp_fwd);
        end
        if (halt !== m_halt) begin
            report_mismatch("halt", word_t'(halt), word_t'(m_halt));
        end
        if (rdat1 !== exp_r1) begin
            report_mismatch($sformatf("rdat1 (r%0d)", rsel1), rdat1, exp_r1);
        end
        if (rdat2 !== exp_r2) begin
            report_mismatch($sformatf("rdat2 (r%0d)", rsel2), rdat2, exp_r2);
        end
    endtask

    // idle cycles until halt reaches the wanted level
    task automatic wait_for_halt(input logic want, output bit seen);
        seen = 1'b0;
        for (int n = 0; n < HALT_LIMIT && !seen; n++) begin
            model_edge();
            drive_idle();
            check_outputs();
            if (halt === want) begin
                seen = 1'b1;
            end
        end
    endtask

    initial begin
        bit seen;
        void'($urandom(32'hb2e1));
        errors     = 0;
        timeouts   = 0;
        nRST       = 1'b0;
        ex_rw      = '0;
        ex_reg_wen = 1'b0;
        ex_wbsel   = WB_ALU;
        ex_halt    = 1'b0;
        ex_npc     = '0;
        ex_port_a  = '0;
        ex_port_b  = '0;
        ex_port_o  = '0;
        ex_imm_ext = '0;
        ex_instr   = '0;
        ex_dren    = 1'b0;
        ex_dwen    = 1'b0;
        ihit       = 1'b0;
        flush      = 1'b0;
        freeze     = 1'b0;
        rsel1      = '0;
        rsel2      = '0;
        clear_model_latch();
        for (int r = 0; r < NUM_REGS; r++) begin
            model_regs[r] = '0;
        end
        repeat (5) @(posedge CLK);
        nRST <= 1'b1;

        for (int i = 0; i < NUM_CYCLES; i++) begin
            model_edge();
            drive_random();
            check_outputs();
        end

        // halt shows one capture later, flush clears it
        model_edge();
        drive_idle();
        ex_halt <= 1'b1;
        ihit    <= 1'b1;
        check_outputs();
        wait_for_halt(1'b1, seen);
        if (!seen) begin
            $display("Timeout: halt output did not rise within %0d cycles", HALT_LIMIT);
            timeouts++;
        end
        model_edge();
        drive_idle();
        flush <= 1'b1;
        check_outputs();
        wait_for_halt(1'b0, seen);
        if (!seen) begin
            $display("Timeout: halt output did not clear within %0d cycles", HALT_LIMIT);
            timeouts++;
        end

        // read every register back
        for (int r = 0; r < NUM_REGS; r += 2) begin
            model_edge();
            drive_idle();
            rsel1 <= regbits_t'(r);
            rsel2 <= regbits_t'(r + 1);
            check_outputs();
        end

        $display("Errors: %0d mismatches, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== list.f ====
src/cpu_types_pkg.sv
src/pipe_types_pkg.sv
src/data_memory.sv
src/memory_stage.sv
src/writeback_stage.sv
src/register_file.sv
src/mem_wb_top.sv
bench/mem_wb_asserts.sv
bench/mem_wb_tb.sv

// ==== Bender.yml ====
package:
  name: mem_wb

sources:
  - src/cpu_types_pkg.sv
  - src/pipe_types_pkg.sv
  - src/data_memory.sv
  - src/memory_stage.sv
  - src/writeback_stage.sv
  - src/register_file.sv
  - src/mem_wb_top.sv
  - target: test
    files:
      - bench/mem_wb_asserts.sv
      - bench/mem_wb_tb.sv
